/* include/rob_consts.svh */
// reorder buffer constants
// sizes of the per-thread queues, the register files and the PC
// the index widths are derived from the sizes

`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// entries per thread queue, must be a power of two
`define ROB_DEPTH 8
`define ROB_IDX_W $clog2(`ROB_DEPTH)

// physical register file
`define PRF_SIZE 64
`define PRN_W $clog2(`PRF_SIZE)

`define ARN_W 5		// 32 architectural registers

`define PC_W 64

`endif

/* hw/rob_pkg.sv */
// reorder buffer types
// tags, dispatch and completion records, stored entries
// and the records that leave the buffer on commit

`include "rob_consts.svh"

package rob_pkg;

	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

	// thread bit is set for thread 2
	typedef struct packed
	{
		logic is_thread2;
		rob_idx_t idx;
	} rob_tag_t;

	// one dispatched instruction
	typedef struct packed
	{
		logic [`PC_W-1:0] pc;
		logic [`ARN_W-1:0] arn_dest;
		logic [`PRN_W-1:0] prn_dest;
		logic is_branch;
	} rob_inst_t;

	// completion report from one functional unit
	typedef struct packed
	{
		logic valid;
		rob_tag_t tag;
		logic mispredict;
		logic [`PC_W-1:0] target_pc;
	} rob_done_t;

	typedef struct packed
	{
		logic [`PC_W-1:0] pc;
		logic [`ARN_W-1:0] arn_dest;
		logic [`PRN_W-1:0] prn_dest;
		logic is_branch;
		logic executed;			// set by a completion
		logic mispredict;
		logic [`PC_W-1:0] target_pc;
	} rob_entry_t;

	typedef struct packed
	{
		logic valid;
		logic is_thread1;
		logic [`PC_W-1:0] pc;
		logic [`PC_W-1:0] target_pc;
		logic is_branch;
		logic mispredict;
		logic [`ARN_W-1:0] arn_dest;
		logic [`PRN_W-1:0] prn_dest;
	} rob_commit_t;

	// source of a commit slot
	typedef enum logic [1:0]
	{
		src_none = 2'd0,
		src_t1 = 2'd1,
		src_t2 = 2'd2
	} commit_src_e;

endpackage

/* hw/rob_thread_queue.sv */
// reorder buffer queue for one thread
// circular store of ROB_DEPTH entries, head and tail carry a wrap bit
// writes a dispatched pair at the tail, marks entries executed on completion,
// retires from the head and drops everything younger than the head on flush

`include "rob_consts.svh"

module rob_thread_queue
	import rob_pkg::*;
#(
	parameter bit thread_id = 1'b0		// 0 serves thread 1, 1 serves thread 2
)
(
	input logic clock,
	input logic reset,
	input logic thread1,
	input logic load,
	input rob_inst_t inst1,
	input rob_inst_t inst2,
	input rob_done_t done1,
	input rob_done_t done2,
	input logic [1:0] retire_count,
	input logic flush,
	output rob_tag_t tag1,
	output rob_tag_t tag2,
	output rob_entry_t head_entry,
	output rob_entry_t second_entry,
	output logic head_valid,
	output logic second_valid,
	output logic full
);

	localparam int ptr_w = `ROB_IDX_W + 1;

	rob_entry_t entries [`ROB_DEPTH];

	logic [ptr_w-1:0] head;
	logic [ptr_w-1:0] tail;
	logic [ptr_w-1:0] next_head;
	logic [ptr_w-1:0] count;
	rob_idx_t head_idx;
	rob_idx_t head_next_idx;
	rob_idx_t tail_idx;
	rob_idx_t tail_next_idx;
	rob_idx_t offset [`ROB_DEPTH];		// distance of each slot from the head
	logic [`ROB_DEPTH-1:0] occupied;
	logic [`ROB_DEPTH-1:0] done1_hit;
	logic [`ROB_DEPTH-1:0] done2_hit;
	logic mine;
	logic wr_en;

	// a freshly dispatched entry has not executed yet
	function automatic rob_entry_t new_entry(input rob_inst_t inst);
		rob_entry_t e;
		e = '0;
		e.pc = inst.pc;
		e.arn_dest = inst.arn_dest;
		e.prn_dest = inst.prn_dest;
		e.is_branch = inst.is_branch;
		return e;
	endfunction

	assign head_idx = head[`ROB_IDX_W-1:0];
	assign tail_idx = tail[`ROB_IDX_W-1:0];
	assign head_next_idx = head_idx + 1'b1;		// wraps with the power-of-two depth
	assign tail_next_idx = tail_idx + 1'b1;

	assign count = tail - head;
	assign next_head = head + ptr_w'(retire_count);

	// fewer than two free entries
	assign full = count > (`ROB_DEPTH - 2);
	assign head_valid = count != '0;
	assign second_valid = count > 1;

	assign mine = load && (thread1 == (thread_id == 1'b0));
	assign wr_en = mine && !full && !flush;		// a flush cycle drops the pair

	assign head_entry = entries[head_idx];
	assign second_entry = entries[head_next_idx];

	// tags read zero unless the pair is accepted here
	always_comb
	begin
		tag1 = '0;
		tag2 = '0;
		if (wr_en)
		begin
			tag1.is_thread2 = thread_id;
			tag1.idx = tail_idx;
			tag2.is_thread2 = thread_id;
			tag2.idx = tail_next_idx;
		end
	end

	// a completion only counts for a live entry of this thread
	always_comb
	begin
		for (int i = 0; i < `ROB_DEPTH; i++)
		begin
			offset[i] = rob_idx_t'(i) - head_idx;
			occupied[i] = {1'b0, offset[i]} < count;
			done1_hit[i] = done1.valid && (done1.tag.is_thread2 == thread_id) &&
				(done1.tag.idx == rob_idx_t'(i)) && occupied[i];
			done2_hit[i] = done2.valid && (done2.tag.is_thread2 == thread_id) &&
				(done2.tag.idx == rob_idx_t'(i)) && occupied[i];
		end
	end

	// entry store
	always_ff @(posedge clock)
	begin
		if (wr_en)
		begin
			entries[tail_idx] <= new_entry(inst1);
			entries[tail_next_idx] <= new_entry(inst2);
		end
		for (int i = 0; i < `ROB_DEPTH; i++)
		begin
			if (done1_hit[i])
			begin
				entries[i].executed <= 1'b1;
				entries[i].mispredict <= done1.mispredict;
				entries[i].target_pc <= done1.target_pc;
			end
			else if (done2_hit[i])
			begin
				entries[i].executed <= 1'b1;
				entries[i].mispredict <= done2.mispredict;
				entries[i].target_pc <= done2.target_pc;
			end
		end
	end

	// pointers
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			head <= next_head;
			if (flush)
				tail <= next_head;		// younger entries are gone
			else if (wr_en)
				tail <= tail + ptr_w'(2);
		end
	end

endmodule

/* hw/rob_commit_select.sv */
// commit selector for the two thread queues
// picks up to two executed entries in program order per cycle,
// thread 1 first, and builds the commit records
// also returns the retire count and flush request for each thread

module rob_commit_select
	import rob_pkg::*;
(
	input rob_entry_t t1_head,
	input rob_entry_t t1_second,
	input rob_entry_t t2_head,
	input rob_entry_t t2_second,
	input logic t1_head_valid,
	input logic t1_second_valid,
	input logic t2_head_valid,
	input logic t2_second_valid,
	output rob_commit_t commit1,
	output rob_commit_t commit2,
	output logic [1:0] t1_retire,
	output logic [1:0] t2_retire,
	output logic t1_flush,
	output logic t2_flush
);

	commit_src_e slot1_src;
	commit_src_e slot2_src;
	rob_entry_t slot1_entry;
	rob_entry_t slot2_entry;
	logic slot1_kill;		// mispredicted branch in slot 1
	logic slot2_kill;
	logic t1_ready;
	logic t2_ready;
	logic t1_second_ready;
	logic t2_second_ready;

	function automatic rob_commit_t to_commit(input rob_entry_t e, input logic is_t1);
		rob_commit_t c;
		c.valid = 1'b1;
		c.is_thread1 = is_t1;
		c.pc = e.pc;
		c.target_pc = e.target_pc;
		c.is_branch = e.is_branch;
		c.mispredict = e.mispredict;
		c.arn_dest = e.arn_dest;
		c.prn_dest = e.prn_dest;
		return c;
	endfunction

	assign t1_ready = t1_head_valid && t1_head.executed;
	assign t2_ready = t2_head_valid && t2_head.executed;
	assign t1_second_ready = t1_second_valid && t1_second.executed;
	assign t2_second_ready = t2_second_valid && t2_second.executed;

	always_comb
	begin
		slot1_src = src_none;
		slot1_entry = '0;
		if (t1_ready)
		begin
			slot1_src = src_t1;
			slot1_entry = t1_head;
		end
		else if (t2_ready)
		begin
			slot1_src = src_t2;
			slot1_entry = t2_head;
		end
		slot1_kill = slot1_entry.is_branch && slot1_entry.mispredict;

		// nothing follows a mispredicted branch in the same cycle
		slot2_src = src_none;
		slot2_entry = '0;
		if (!slot1_kill)
		begin
			if (slot1_src == src_t1 && t1_second_ready)
			begin
				slot2_src = src_t1;
				slot2_entry = t1_second;
			end
			else if (slot1_src == src_t2 && t2_second_ready)
			begin
				slot2_src = src_t2;
				slot2_entry = t2_second;
			end
			else if (slot1_src == src_t1 && t2_ready)		// other thread fills the gap
			begin
				slot2_src = src_t2;
				slot2_entry = t2_head;
			end
		end
		slot2_kill = slot2_entry.is_branch && slot2_entry.mispredict;
	end

	assign commit1 = (slot1_src == src_none) ? '0 : to_commit(slot1_entry, slot1_src == src_t1);
	assign commit2 = (slot2_src == src_none) ? '0 : to_commit(slot2_entry, slot2_src == src_t1);

	assign t1_retire = {1'b0, slot1_src == src_t1} + {1'b0, slot2_src == src_t1};
	assign t2_retire = {1'b0, slot1_src == src_t2} + {1'b0, slot2_src == src_t2};

	assign t1_flush = (slot1_src == src_t1 && slot1_kill) || (slot2_src == src_t1 && slot2_kill);
	assign t2_flush = (slot1_src == src_t2 && slot1_kill) || (slot2_src == src_t2 && slot2_kill);

endmodule

/* hw/rob_top.sv */
// two-thread reorder buffer
// one queue per thread and a shared commit selector
// the dispatched pair goes to the thread named by thread1, tags come back
// in the same cycle, up to two instructions commit per cycle

module rob_top
	import rob_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic thread1,
	input logic load,
	input rob_inst_t inst1,
	input rob_inst_t inst2,
	input rob_done_t done1,
	input rob_done_t done2,
	output rob_tag_t tag1,
	output rob_tag_t tag2,
	output rob_commit_t commit1,
	output rob_commit_t commit2,
	output logic t1_full,
	output logic t2_full
);

	rob_tag_t t1_tag1;
	rob_tag_t t1_tag2;
	rob_tag_t t2_tag1;
	rob_tag_t t2_tag2;
	rob_entry_t t1_head;
	rob_entry_t t1_second;
	rob_entry_t t2_head;
	rob_entry_t t2_second;
	logic t1_head_valid;
	logic t1_second_valid;
	logic t2_head_valid;
	logic t2_second_valid;
	logic [1:0] t1_retire;
	logic [1:0] t2_retire;
	logic t1_flush;
	logic t2_flush;

	// thread 1 queue
	rob_thread_queue #(.thread_id(1'b0)) t1_queue_inst
	(
		.clock(clock),
		.reset(reset),
		.thread1(thread1),
		.load(load),
		.inst1(inst1),
		.inst2(inst2),
		.done1(done1),
		.done2(done2),
		.retire_count(t1_retire),
		.flush(t1_flush),
		.tag1(t1_tag1),
		.tag2(t1_tag2),
		.head_entry(t1_head),
		.second_entry(t1_second),
		.head_valid(t1_head_valid),
		.second_valid(t1_second_valid),
		.full(t1_full)
	);

	rob_thread_queue #(.thread_id(1'b1)) t2_queue_inst
	(
		.clock(clock),
		.reset(reset),
		.thread1(thread1),
		.load(load),
		.inst1(inst1),
		.inst2(inst2),
		.done1(done1),
		.done2(done2),
		.retire_count(t2_retire),
		.flush(t2_flush),
		.tag1(t2_tag1),
		.tag2(t2_tag2),
		.head_entry(t2_head),
		.second_entry(t2_second),
		.head_valid(t2_head_valid),
		.second_valid(t2_second_valid),
		.full(t2_full)
	);

	rob_commit_select commit_select_inst
	(
		.t1_head(t1_head),
		.t1_second(t1_second),
		.t2_head(t2_head),
		.t2_second(t2_second),
		.t1_head_valid(t1_head_valid),
		.t1_second_valid(t1_second_valid),
		.t2_head_valid(t2_head_valid),
		.t2_second_valid(t2_second_valid),
		.commit1(commit1),
		.commit2(commit2),
		.t1_retire(t1_retire),
		.t2_retire(t2_retire),
		.t1_flush(t1_flush),
		.t2_flush(t2_flush)
	);

	// tags come from the queue that took the pair
	assign tag1 = thread1 ? t1_tag1 : t2_tag1;
	assign tag2 = thread1 ? t1_tag2 : t2_tag2;

endmodule

/* tests/rob_tb.sv */
// testbench for the two-thread reorder buffer
// replays the test data one line per cycle: drives dispatch and completion,
// then checks tags, commit records and full flags against the expected columns

`include "rob_consts.svh"

module rob_tb
	import rob_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int sample_delay = 3;	// outputs are settled well before the rising edge
	localparam int fields = 30;		// values per data line
	localparam int max_vectors = 64;
	localparam int slack_cycles = 50;
	localparam string data_file = "tests/rob_testdata.txt";

	// one cycle of stimulus and expected outputs
	typedef struct packed
	{
		logic load;
		logic thread1;
		rob_inst_t inst1;
		rob_inst_t inst2;
		rob_done_t done1;
		rob_done_t done2;
		rob_tag_t tag1;
		rob_tag_t tag2;
		rob_commit_t commit1;
		rob_commit_t commit2;
		logic t1_full;
		logic t2_full;
	} vector_t;

	logic clock;
	logic reset;
	logic thread1;
	logic load;
	rob_inst_t inst1;
	rob_inst_t inst2;
	rob_done_t done1;
	rob_done_t done2;
	rob_tag_t tag1;
	rob_tag_t tag2;
	rob_commit_t commit1;
	rob_commit_t commit2;
	logic t1_full;
	logic t2_full;

	logic [`PC_W-1:0] words [fields*max_vectors];
	vector_t vectors [max_vectors];
	int num_vectors = 0;
	int tag_errors = 0;
	int commit_errors = 0;
	int full_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	rob_top rob_top_inst
	(
		.clock(clock),
		.reset(reset),
		.thread1(thread1),
		.load(load),
		.inst1(inst1),
		.inst2(inst2),
		.done1(done1),
		.done2(done2),
		.tag1(tag1),
		.tag2(tag2),
		.commit1(commit1),
		.commit2(commit2),
		.t1_full(t1_full),
		.t2_full(t2_full)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// register numbers follow from the pc, so a data line only carries the pc
	function automatic rob_inst_t make_inst(input logic [`PC_W-1:0] pc, input logic br);
		rob_inst_t i;
		i.pc = pc;
		i.arn_dest = pc[2 +: `ARN_W];
		i.prn_dest = pc[3 +: `PRN_W];
		i.is_branch = br;
		return i;
	endfunction

	function automatic rob_done_t make_done(input int b);
		rob_done_t d;
		d.valid = words[b][0];
		d.tag = rob_tag_t'(words[b+1][`ROB_IDX_W:0]);
		d.mispredict = words[b+2][0];
		d.target_pc = words[b+3];
		return d;
	endfunction

	function automatic rob_commit_t make_commit(input int b);
		rob_commit_t c;
		rob_inst_t i;
		i = make_inst(words[b+2], words[b+3][0]);
		c = '0;
		if (words[b][0])	// an idle slot reads all zeros
		begin
			c.valid = 1'b1;
			c.is_thread1 = words[b+1][0];
			c.pc = i.pc;
			c.target_pc = words[b+5];
			c.is_branch = i.is_branch;
			c.mispredict = words[b+4][0];
			c.arn_dest = i.arn_dest;
			c.prn_dest = i.prn_dest;
		end
		return c;
	endfunction

	function automatic vector_t build_vector(input int b);
		vector_t v;
		v.load = words[b][0];
		v.thread1 = words[b+1][0];
		v.inst1 = make_inst(words[b+2], words[b+3][0]);
		v.inst2 = make_inst(words[b+4], words[b+5][0]);
		v.done1 = make_done(b + 6);
		v.done2 = make_done(b + 10);
		v.tag1 = rob_tag_t'(words[b+14][`ROB_IDX_W:0]);
		v.tag2 = rob_tag_t'(words[b+15][`ROB_IDX_W:0]);
		v.commit1 = make_commit(b + 16);
		v.commit2 = make_commit(b + 22);
		v.t1_full = words[b+28][0];
		v.t2_full = words[b+29][0];
		return v;
	endfunction

	task automatic load_vectors(output bit ok);
		int fd;
		int used;
		ok = 1'b0;
		for (int i = 0; i < fields*max_vectors; i++)
			words[i] = '1;		// marks values the file did not fill
		fd = $fopen(data_file, "r");
		if (fd == 0)
		begin
			$display("cannot open the test data file %s", data_file);
			return;
		end
		$fclose(fd);
		$readmemh(data_file, words);
		used = 0;
		while (used < fields*max_vectors && words[used] !== '1)
			used++;
		if (used == 0 || used % fields != 0)
		begin
			$display("test data file is short: %0d values do not fill whole lines", used);
			return;
		end
		num_vectors = used / fields;
		for (int n = 0; n < num_vectors; n++)
			vectors[n] = build_vector(n * fields);
		ok = 1'b1;
	endtask

	task automatic apply_vector(input int n);
		load = vectors[n].load;
		thread1 = vectors[n].thread1;
		inst1 = vectors[n].inst1;
		inst2 = vectors[n].inst2;
		done1 = vectors[n].done1;
		done2 = vectors[n].done2;
	endtask

	function automatic string commit_text(input rob_commit_t c);
		return $sformatf("v%0d t1=%0d pc %0h tgt %0h br%0d mp%0d arn %0d prn %0d", c.valid,
			c.is_thread1, c.pc, c.target_pc, c.is_branch, c.mispredict, c.arn_dest, c.prn_dest);
	endfunction

	task automatic check_tag(input int n, input string name, input rob_tag_t got,
		input rob_tag_t exp);
		if (got !== exp)
		begin
			tag_errors++;
			$display("MISMATCH at %0t: vector %0d %s got %0h expected %0h", $time, n, name,
				got, exp);
		end
	endtask

	task automatic check_commit(input int n, input string name, input rob_commit_t got,
		input rob_commit_t exp);
		if (got !== exp)
		begin
			commit_errors++;
			$display("MISMATCH at %0t: vector %0d %s got %s expected %s", $time, n, name,
				commit_text(got), commit_text(exp));
		end
	endtask

	task automatic check_full(input int n, input string name, input logic got,
		input logic exp);
		if (got !== exp)
		begin
			full_errors++;
			$display("MISMATCH at %0t: vector %0d %s got %0d expected %0d", $time, n, name,
				got, exp);
		end
	endtask

	task automatic check_vector(input int n);
		check_tag(n, "tag1", tag1, vectors[n].tag1);
		check_tag(n, "tag2", tag2, vectors[n].tag2);
		check_commit(n, "commit1", commit1, vectors[n].commit1);
		check_commit(n, "commit2", commit2, vectors[n].commit2);
		check_full(n, "t1_full", t1_full, vectors[n].t1_full);
		check_full(n, "t2_full", t2_full, vectors[n].t2_full);
	endtask

	// run limit counts only cycles after reset
	always @(posedge clock)
	begin
		if (!reset)
		begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit)
			begin
				$display("timeout: the run went past %0d cycles", cycle_limit);
				$display("Testbench failed");
				$finish;
			end
		end
	end

	initial
	begin
		bit ok;
		reset = 1'b1;
		load = 1'b0;
		thread1 = 1'b0;
		inst1 = '0;
		inst2 = '0;
		done1 = '0;
		done2 = '0;
		load_vectors(ok);
		if (!ok)
		begin
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			cycle_limit = num_vectors + slack_cycles;
			repeat (reset_cycles) @(posedge clock);
			@(negedge clock);
			reset = 1'b0;
			for (int n = 0; n < num_vectors; n++)
			begin
				apply_vector(n);
				#sample_delay;
				check_vector(n);
				@(negedge clock);
			end
			$display("errors: tag %0d, commit %0d, full %0d", tag_errors, commit_errors,
				full_errors);
			if (tag_errors + commit_errors + full_errors == 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

endmodule

/* tests/rob_testdata.txt */
// ld th pc1 br1 pc2 br2 | done1 v tag mp tgt | done2 v tag mp tgt | tag1 tag2 |
// commit1 v t1 pc br mp tgt | commit2 v t1 pc br mp tgt | t1_full t2_full, all hex
1 1 100 0 104 0  0 0 0 000  0 0 0 000  0 1  0 0 000 0 0 000  0 0 000 0 0 000  0 0
1 0 200 0 204 0  1 1 0 108  0 0 0 000  8 9  0 0 000 0 0 000  0 0 000 0 0 000  0 0
1 1 108 0 10c 0  1 8 0 208  0 0 0 000  2 3  0 0 000 0 0 000  0 0 000 0 0 000  0 0
0 0 000 0 000 0  1 0 0 104  0 0 0 000  0 0  1 0 200 0 0 208  0 0 000 0 0 000  0 0
0 0 000 0 000 0  1 9 0 20c  1 2 0 10c  0 0  1 1 100 0 0 104  1 1 104 0 0 108  0 0
1 1 110 0 114 0  0 0 0 000  0 0 0 000  4 5  1 1 108 0 0 10c  1 0 204 0 0 20c  0 0
1 1 118 1 11c 0  1 3 0 110  0 0 0 000  6 7  0 0 000 0 0 000  0 0 000 0 0 000  0 0
// index wrap, then thread 1 fills up
1 1 120 0 124 0  1 5 0 118  0 0 0 000  0 1  1 1 10c 0 0 110  0 0 000 0 0 000  0 0
1 1 128 0 12c 0  0 0 0 000  0 0 0 000  2 3  0 0 000 0 0 000  0 0 000 0 0 000  0 0
1 1 130 0 134 0  1 4 0 114  0 0 0 000  0 0  0 0 000 0 0 000  0 0 000 0 0 000  1 0
0 0 000 0 000 0  1 6 1 300  1 0 0 124  0 0  1 1 110 0 0 114  1 1 114 0 0 118  1 0
// mispredicted branch commits and flushes thread 1
1 1 140 0 144 0  0 0 0 000  0 0 0 000  0 0  1 1 118 1 1 300  0 0 000 0 0 000  0 0
1 1 400 0 404 0  1 0 0 999  0 0 0 000  7 0  0 0 000 0 0 000  0 0 000 0 0 000  0 0
1 0 220 0 224 0  1 0 0 408  0 0 0 000  a b  0 0 000 0 0 000  0 0 000 0 0 000  0 0
0 0 000 0 000 0  1 7 0 404  1 a 0 224  0 0  0 0 000 0 0 000  0 0 000 0 0 000  0 0
0 0 000 0 000 0  1 b 0 228  0 0 0 000  0 0  1 1 400 0 0 404  1 1 404 0 0 408  0 0
0 0 000 0 000 0  0 0 0 000  0 0 0 000  0 0  1 0 220 0 0 224  1 0 224 0 0 228  0 0
0 0 000 0 000 0  0 0 0 000  0 0 0 000  0 0  0 0 000 0 0 000  0 0 000 0 0 000  0 0

/* sim.f */
+incdir+include
hw/rob_pkg.sv
hw/rob_thread_queue.sv
hw/rob_commit_select.sv
hw/rob_top.sv
tests/rob_tb.sv

/* run.sh */
#!/bin/sh
# builds the reorder buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module rob_tb -o rob_sim
./obj_dir/rob_sim > sim.log
cat sim.log

if grep -q "Testbench failed" sim.log
then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
echo "simulation clean"
